// File: design/telemetry_pkg.sv
`default_nettype none

package telemetry_pkg;

  // Capture word layout
  localparam int SIG_WIDTH = 20;  // Watched status field
  localparam int IGN_WIDTH = 12;  // Stored, never compared
  localparam int LOG_WIDTH = SIG_WIDTH + IGN_WIDTH;  // Ignored field sits on top

  // Capture FIFO
  localparam int FIFO_DEPTH  = 16;
  localparam int PTR_WIDTH   = $clog2(FIFO_DEPTH);
  localparam int LEVEL_WIDTH = PTR_WIDTH + 1;  // Holds 0 to FIFO_DEPTH

  // Transmitter character buffer, one credit per slot
  localparam int TX_CREDITS   = 2;
  localparam int TX_PTR_WIDTH = $clog2(TX_CREDITS);
  localparam int CREDIT_WIDTH = $clog2(TX_CREDITS + 1);

  // Serial timing
  localparam int UART_PRESCALE  = 4;  // Clocks per bit, kept short for simulation
  localparam int PRESCALE_WIDTH = $clog2(UART_PRESCALE);
  localparam int FRAME_BITS     = 10;  // Start, 8 data, stop

  localparam logic [7:0] LINE_FEED = 8'h0A;

  // Dump controller states
  typedef enum logic [1:0] {
    IDLE,
    POP,
    HEX,
    NEWLINE
  } dump_state_t;

endpackage

`default_nettype wire

// File: design/telemetry_logger.sv
`default_nettype none
`timescale 1ns/1ns

module telemetry_logger (
  input  wire                                   clock,
  input  wire                                   usb_rst,
  input  wire                                   enable_i,
  input  wire  [telemetry_pkg::SIG_WIDTH-1:0]   change_i,
  input  wire  [telemetry_pkg::IGN_WIDTH-1:0]   ignore_i,
  input  wire                                   pop_i,
  output logic [telemetry_pkg::LOG_WIDTH-1:0]   word_o,
  output logic                                  empty_o,
  output logic [telemetry_pkg::LEVEL_WIDTH-1:0] level_o,
  output logic                                  overflow_o
);

  logic [telemetry_pkg::LOG_WIDTH-1:0]   mem [telemetry_pkg::FIFO_DEPTH];
  logic [telemetry_pkg::SIG_WIDTH-1:0]   last_q;
  logic [telemetry_pkg::LOG_WIDTH-1:0]   wr_word_q;
  logic [telemetry_pkg::PTR_WIDTH-1:0]   wr_ptr_q;
  logic [telemetry_pkg::PTR_WIDTH-1:0]   rd_ptr_q;
  logic [telemetry_pkg::LEVEL_WIDTH-1:0] count_q;
  logic                                  armed_q;
  logic                                  wr_q;
  logic                                  overflow_q;
  logic                                  capture_w;
  logic                                  full_w;
  logic                                  push_w;
  logic                                  pull_w;

  // First enabled cycle always captures, then only on a change
  assign capture_w = enable_i && (armed_q || (change_i != last_q));

  always_ff @(posedge clock) begin
    if (usb_rst) begin
      armed_q <= 1'b1;
      wr_q    <= 1'b0;
    end else begin
      armed_q <= !enable_i;  // Re-arms while capture is off
      wr_q    <= capture_w;
    end
  end

  // Word to be written on the following edge
  always_ff @(posedge clock) begin
    if (capture_w) begin
      last_q    <= change_i;
      wr_word_q <= {ignore_i, change_i};
    end
  end

  assign full_w = (count_q == telemetry_pkg::LEVEL_WIDTH'(telemetry_pkg::FIFO_DEPTH));
  assign push_w = wr_q && !full_w;  // Dropped when full
  assign pull_w = pop_i && !empty_o;

  always_ff @(posedge clock) begin
    if (usb_rst) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (push_w) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at the depth
      if (pull_w) rd_ptr_q <= rd_ptr_q + 1'b1;

      case ({push_w, pull_w})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase

      // Sticky until reset
      if (wr_q && full_w) begin
        overflow_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (push_w) begin
      mem[wr_ptr_q] <= wr_word_q;
    end
  end

  assign word_o     = mem[rd_ptr_q];  // Oldest entry
  assign empty_o    = (count_q == '0);
  assign level_o    = count_q;
  assign overflow_o = overflow_q;

endmodule

`default_nettype wire

// File: design/dump_fsm.sv
`default_nettype none
`timescale 1ns/1ns

module dump_fsm (
  input  wire                                 clock,
  input  wire                                 usb_rst,
  input  wire                                 start_i,
  input  wire  [telemetry_pkg::LOG_WIDTH-1:0] word_i,
  input  wire                                 empty_i,
  output logic                                pop_o,
  output logic                                char_valid_o,
  output logic [7:0]                          char_data_o,
  input  wire                                 credit_return_i,
  output logic                                dumping_o
);

  telemetry_pkg::dump_state_t             state_q;
  telemetry_pkg::dump_state_t             state_d;
  logic [telemetry_pkg::LOG_WIDTH-1:0]    shift_q;
  logic [2:0]                             nibble_q;
  logic [telemetry_pkg::CREDIT_WIDTH-1:0] credit_q;
  logic                                   has_credit_w;
  logic                                   emit_w;

  // Upper-case ASCII for one nibble
  function automatic logic [7:0] hex_ascii(input logic [3:0] nibble);
    if (nibble < 4'd10) begin
      return 8'h30 + {4'h0, nibble};
    end
    return 8'h37 + {4'h0, nibble};  // 'A' minus ten
  endfunction

  assign has_credit_w = (credit_q != '0);
  assign emit_w = (state_q == telemetry_pkg::HEX) || (state_q == telemetry_pkg::NEWLINE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      telemetry_pkg::IDLE: begin
        if (start_i && !empty_i) state_d = telemetry_pkg::POP;
      end
      telemetry_pkg::POP: begin
        state_d = empty_i ? telemetry_pkg::IDLE : telemetry_pkg::HEX;
      end
      telemetry_pkg::HEX: begin
        if (has_credit_w && (nibble_q == 3'd7)) state_d = telemetry_pkg::NEWLINE;
      end
      telemetry_pkg::NEWLINE: begin
        // Late captures keep the dump going
        if (has_credit_w) state_d = empty_i ? telemetry_pkg::IDLE : telemetry_pkg::POP;
      end
      default: state_d = telemetry_pkg::IDLE;
    endcase
  end

  assign pop_o        = (state_q == telemetry_pkg::POP) && !empty_i;
  assign char_valid_o = emit_w && has_credit_w;  // Each one spends a credit
  assign char_data_o  = (state_q == telemetry_pkg::NEWLINE) ? telemetry_pkg::LINE_FEED
                                                             : hex_ascii(shift_q[31:28]);
  assign dumping_o    = (state_q != telemetry_pkg::IDLE);

  always_ff @(posedge clock) begin
    if (usb_rst) begin
      state_q  <= telemetry_pkg::IDLE;
      nibble_q <= '0;
      credit_q <= telemetry_pkg::CREDIT_WIDTH'(telemetry_pkg::TX_CREDITS);
    end else begin
      state_q <= state_d;

      if (state_q == telemetry_pkg::POP) begin
        nibble_q <= '0;
      end else if ((state_q == telemetry_pkg::HEX) && has_credit_w) begin
        nibble_q <= nibble_q + 1'b1;
      end

      case ({char_valid_o, credit_return_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;  // Spend and return cancel
      endcase
    end
  end

  // Most significant nibble goes first
  always_ff @(posedge clock) begin
    if (state_q == telemetry_pkg::POP) begin
      shift_q <= word_i;
    end else if ((state_q == telemetry_pkg::HEX) && has_credit_w) begin
      shift_q <= {shift_q[telemetry_pkg::LOG_WIDTH-5:0], 4'h0};
    end
  end

endmodule

`default_nettype wire

// File: design/baud_timer.sv
`default_nettype none
`timescale 1ns/1ns

module baud_timer (
  input  wire        clock,
  input  wire        usb_rst,
  input  wire        frame_start_i,
  output logic       bit_tick_o,
  output logic [3:0] bit_index_o,
  output logic       frame_done_o
);

  logic                                     active_q;
  logic [telemetry_pkg::PRESCALE_WIDTH-1:0] presc_q;
  logic [3:0]                               index_q;

  // Tick on the last clock of each bit
  assign bit_tick_o = active_q &&
      (presc_q == telemetry_pkg::PRESCALE_WIDTH'(telemetry_pkg::UART_PRESCALE - 1));
  assign frame_done_o = bit_tick_o && (index_q == 4'(telemetry_pkg::FRAME_BITS - 1));
  assign bit_index_o  = index_q;

  always_ff @(posedge clock) begin
    if (usb_rst) begin
      active_q <= 1'b0;
      presc_q  <= '0;
      index_q  <= '0;
    end else if (frame_start_i) begin  // Also restarts right after a stop bit
      active_q <= 1'b1;
      presc_q  <= '0;
      index_q  <= '0;
    end else if (active_q) begin
      if (bit_tick_o) begin
        presc_q <= '0;
        if (frame_done_o) begin
          active_q <= 1'b0;
          index_q  <= '0;
        end else begin
          index_q <= index_q + 1'b1;
        end
      end else begin
        presc_q <= presc_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/uart_tx_shift.sv
`default_nettype none
`timescale 1ns/1ns

module uart_tx_shift (
  input  wire        clock,
  input  wire        usb_rst,
  input  wire        char_valid_i,
  input  wire  [7:0] char_data_i,
  output logic       credit_return_o,
  input  wire        bit_tick_i,
  input  wire  [3:0] bit_index_i,
  input  wire        frame_done_i,
  output logic       frame_start_o,
  output logic       tx_o,
  output logic       busy_o
);

  logic [7:0]                             buf_q [telemetry_pkg::TX_CREDITS];
  logic [telemetry_pkg::TX_PTR_WIDTH-1:0] wr_ptr_q;
  logic [telemetry_pkg::TX_PTR_WIDTH-1:0] rd_ptr_q;
  logic [telemetry_pkg::CREDIT_WIDTH-1:0] count_q;
  logic [telemetry_pkg::FRAME_BITS-1:0]   frame_q;
  logic                                   active_q;
  logic                                   load_w;

  function automatic logic [telemetry_pkg::TX_PTR_WIDTH-1:0] next_ptr(
      input logic [telemetry_pkg::TX_PTR_WIDTH-1:0] ptr);
    if (ptr == telemetry_pkg::TX_PTR_WIDTH'(telemetry_pkg::TX_CREDITS - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Next frame may follow the stop bit with no gap
  assign load_w          = (count_q != '0) && (!active_q || frame_done_i);
  assign frame_start_o   = load_w;
  assign credit_return_o = load_w;  // Slot freed as the character leaves
  assign tx_o            = frame_q[0];
  assign busy_o          = active_q || (count_q != '0);

  // Credits guarantee a free slot, so no full check
  always_ff @(posedge clock) begin
    if (char_valid_i) begin
      buf_q[wr_ptr_q] <= char_data_i;
    end
  end

  always_ff @(posedge clock) begin
    if (usb_rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      active_q <= 1'b0;
      frame_q  <= '1;  // Line idles high
    end else begin
      if (char_valid_i) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (load_w) rd_ptr_q <= next_ptr(rd_ptr_q);

      case ({char_valid_i, load_w})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase

      if (load_w) begin
        frame_q  <= {1'b1, buf_q[rd_ptr_q], 1'b0};  // Stop, data LSB first, start
        active_q <= 1'b1;
      end else if (frame_done_i) begin
        frame_q  <= '1;
        active_q <= 1'b0;
      end else if (bit_tick_i && (bit_index_i != 4'(telemetry_pkg::FRAME_BITS - 1))) begin
        frame_q <= {1'b1, frame_q[telemetry_pkg::FRAME_BITS-1:1]};
      end
    end
  end

endmodule

`default_nettype wire

// File: design/telemetry_uart_top.sv
`default_nettype none
`timescale 1ns/1ns

module telemetry_uart_top (
  input  wire                                   clock,
  input  wire                                   usb_rst,
  input  wire                                   enable_i,
  input  wire  [telemetry_pkg::SIG_WIDTH-1:0]   change_i,
  input  wire  [telemetry_pkg::IGN_WIDTH-1:0]   ignore_i,
  input  wire                                   start_i,
  output logic                                  tx_o,
  output logic                                  dumping_o,
  output logic                                  overflow_o,
  output logic [telemetry_pkg::LEVEL_WIDTH-1:0] level_o,
  output logic                                  busy_o
);

  wire [telemetry_pkg::LOG_WIDTH-1:0] word;
  wire                                empty;
  wire                                pop;
  wire                                char_valid;
  wire [7:0]                          char_data;
  wire                                credit_return;
  wire                                frame_start;
  wire                                bit_tick;
  wire [3:0]                          bit_index;
  wire                                frame_done;

  telemetry_logger u_logger (
    .clock      (clock),
    .usb_rst    (usb_rst),
    .enable_i   (enable_i),
    .change_i   (change_i),
    .ignore_i   (ignore_i),
    .pop_i      (pop),
    .word_o     (word),
    .empty_o    (empty),
    .level_o    (level_o),
    .overflow_o (overflow_o)
  );

  // Words to ASCII hex lines, paced by transmitter credits
  dump_fsm u_dump (
    .clock           (clock),
    .usb_rst         (usb_rst),
    .start_i         (start_i),
    .word_i          (word),
    .empty_i         (empty),
    .pop_o           (pop),
    .char_valid_o    (char_valid),
    .char_data_o     (char_data),
    .credit_return_i (credit_return),
    .dumping_o       (dumping_o)
  );

  baud_timer u_baud (
    .clock         (clock),
    .usb_rst       (usb_rst),
    .frame_start_i (frame_start),
    .bit_tick_o    (bit_tick),
    .bit_index_o   (bit_index),
    .frame_done_o  (frame_done)
  );

  uart_tx_shift u_tx (
    .clock           (clock),
    .usb_rst         (usb_rst),
    .char_valid_i    (char_valid),
    .char_data_i     (char_data),
    .credit_return_o (credit_return),
    .bit_tick_i      (bit_tick),
    .bit_index_i     (bit_index),
    .frame_done_i    (frame_done),
    .frame_start_o   (frame_start),
    .tx_o            (tx_o),
    .busy_o          (busy_o)
  );

endmodule

`default_nettype wire

// File: bench/telemetry_uart_assertions.sv
`default_nettype none
`timescale 1ns/1ns

module telemetry_uart_assertions (
  input wire                                    clock,
  input wire                                    usb_rst,
  input wire [telemetry_pkg::CREDIT_WIDTH-1:0]  credit_i,
  input wire                                    char_valid_i,
  input wire                                    tx_i,
  input wire                                    busy_i
);

  // One credit per buffer slot
  credit_limit: assert property (@(posedge clock) disable iff (usb_rst)
      credit_i <= telemetry_pkg::CREDIT_WIDTH'(telemetry_pkg::TX_CREDITS))
    else $error("credit count above transmitter buffer size");

  valid_needs_credit: assert property (@(posedge clock) disable iff (usb_rst)
      char_valid_i |-> (credit_i != '0))
    else $error("character arrived with no free buffer slot");

  idle_line_high: assert property (@(posedge clock) disable iff (usb_rst)
      !busy_i |-> tx_i)
    else $error("serial line low while transmitter idle");

endmodule

// Free buffer slots mirror the credits held by the controller
bind uart_tx_shift telemetry_uart_assertions u_tx_checks (
  .clock        (clock),
  .usb_rst      (usb_rst),
  .credit_i     (telemetry_pkg::CREDIT_WIDTH'(telemetry_pkg::TX_CREDITS) - count_q),
  .char_valid_i (char_valid_i),
  .tx_i         (tx_o),
  .busy_i       (busy_o)
);

`default_nettype wire

// File: bench/telemetry_uart_tb.sv
`default_nettype none
`timescale 1ns/1ns

module telemetry_uart_tb;

  localparam int NUM_ROWS     = 35;
  localparam int RESET_CYCLES = 10;
  localparam int EXP_WORDS    = 4 + 16 + 6;  // Words returned by the three dumps
  localparam int EXP_CHARS    = EXP_WORDS * 9;
  localparam int BIT_CLOCKS   = telemetry_pkg::UART_PRESCALE;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_ROWS * 2 +
      EXP_CHARS * 10 * BIT_CLOCKS * 2;

  typedef struct packed {
    logic                                enable;
    logic [telemetry_pkg::SIG_WIDTH-1:0] change;
    logic [telemetry_pkg::IGN_WIDTH-1:0] ignore;
  } row_t;

  logic                                  clock = 1'b0;
  logic                                  usb_rst;
  logic                                  enable;
  logic [telemetry_pkg::SIG_WIDTH-1:0]   change;
  logic [telemetry_pkg::IGN_WIDTH-1:0]   ignore;
  logic                                  start;
  wire                                   tx;
  wire                                   dumping;
  wire                                   overflow;
  wire  [telemetry_pkg::LEVEL_WIDTH-1:0] level;
  wire                                   busy;

  row_t        tbl [NUM_ROWS];
  logic [31:0] exp_q[$];  // Reference FIFO contents, oldest first
  logic [7:0]  rx_q[$];   // Characters seen on the serial line
  logic [7:0]  rx_char;
  logic [telemetry_pkg::SIG_WIDTH-1:0] ref_last;
  logic        ref_armed;
  logic        ref_overflow;
  integer      seed = 32'h7d97_01ed;
  int          err_count = 0;
  int          test_err_start = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  telemetry_uart_top dut (
    .clock      (clock),
    .usb_rst    (usb_rst),
    .enable_i   (enable),
    .change_i   (change),
    .ignore_i   (ignore),
    .start_i    (start),
    .tx_o       (tx),
    .dumping_o  (dumping),
    .overflow_o (overflow),
    .level_o    (level),
    .busy_o     (busy)
  );

  always #10 clock = ~clock;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      err_count++;
      $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  function automatic logic [7:0] hex_char(input logic [3:0] value);
    string digits;
    digits = "0123456789ABCDEF";
    return digits[int'(value)];
  endfunction

  task automatic end_test(input string name);
    tests_run++;
    if (err_count == test_err_start) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", tests_run, name, err_count - test_err_start);
    end
    test_err_start = err_count;
  endtask

  task automatic build_table();
    int          i;
    logic [31:0] rnd;
    for (i = 0; i < NUM_ROWS; i++) begin
      rnd = $random(seed);
      tbl[i].ignore = rnd[11:0];
      tbl[i].enable = 1'b1;
    end
    // Capture filter rows
    tbl[0].change = 20'h00001;
    tbl[1].change = 20'h00001;  // Only the ignored field moves
    tbl[2].change = 20'h00A5C;
    tbl[3].change = 20'h12345;
    tbl[3].enable = 1'b0;
    tbl[4].change = 20'h00A5C;  // Re-armed, so captured again
    tbl[5].change = 20'h00A5C;
    tbl[6].change = 20'hFFFFF;
    tbl[7].change = 20'hFFFFF;
    tbl[8].change = 20'h0BEEF;
    tbl[8].enable = 1'b0;
    for (i = 0; i < 20; i++) begin
      tbl[9 + i].change = 20'(32'h40000 + i * 32'h111);  // Twenty distinct values
    end
    tbl[29].change = 20'h5A001;
    tbl[30].change = 20'h5A002;
    tbl[31].change = 20'h5A003;
    tbl[32].change = 20'h6B001;  // Applied while a dump runs
    tbl[33].change = 20'h6B002;
    tbl[34].change = 20'h6B003;
  endtask

  // Drives rows and updates the reference FIFO by the capture rule
  task automatic apply_rows(input int first, input int last);
    int i;
    for (i = first; i <= last; i++) begin
      @(posedge clock);
      enable <= tbl[i].enable;
      change <= tbl[i].change;
      ignore <= tbl[i].ignore;
      if (tbl[i].enable && (ref_armed || (tbl[i].change != ref_last))) begin
        if (exp_q.size() < telemetry_pkg::FIFO_DEPTH) begin
          exp_q.push_back({tbl[i].ignore, tbl[i].change});
        end else begin
          ref_overflow = 1'b1;
        end
        ref_last = tbl[i].change;
      end
      ref_armed = !tbl[i].enable;
    end
    @(posedge clock);
    enable <= 1'b0;
    ref_armed = 1'b1;
    repeat (3) @(posedge clock);  // Let the delayed write land
  endtask

  task automatic pulse_start();
    @(posedge clock);
    start <= 1'b1;
    @(posedge clock);
    start <= 1'b0;
  endtask

  task automatic start_dump();
    pulse_start();
    while (!dumping) @(posedge clock);
  endtask

  task automatic finish_dump();
    while (dumping || busy) @(posedge clock);
    repeat (2 * BIT_CLOCKS) @(posedge clock);
    check_value("dumping_o", 32'(dumping), 32'h0);
    check_value("level_o", 32'(level), 32'h0);
  endtask

  // Compares decoded characters against the reference words
  task automatic check_dump();
    logic [31:0] word;
    logic [7:0]  got;
    int          n;
    check_value("decoded character count", 32'(rx_q.size()), 32'(exp_q.size() * 9));
    while ((exp_q.size() != 0) && (rx_q.size() >= 9)) begin
      word = exp_q.pop_front();
      for (n = 7; n >= 0; n--) begin
        got = rx_q.pop_front();
        check_value("tx_o hex character", 32'(got), 32'(hex_char(word[n*4 +: 4])));
      end
      got = rx_q.pop_front();
      check_value("tx_o line feed", 32'(got), 32'h0A);
    end
    exp_q.delete();
    rx_q.delete();
  endtask

  // Serial decoder, samples each bit near its middle
  always begin
    @(posedge clock);
    if (!usb_rst && (tx == 1'b0)) begin
      repeat (BIT_CLOCKS / 2 - 1) @(posedge clock);
      check_value("tx_o start bit", 32'(tx), 32'h0);
      for (int b = 0; b < 8; b++) begin
        repeat (BIT_CLOCKS) @(posedge clock);
        rx_char[b] = tx;  // LSB first
      end
      repeat (BIT_CLOCKS) @(posedge clock);
      check_value("tx_o stop bit", 32'(tx), 32'h1);
      rx_q.push_back(rx_char);
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("Watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    usb_rst = 1'b1;
    enable = 1'b0;
    change = '0;
    ignore = '0;
    start = 1'b0;
    ref_armed = 1'b1;
    ref_last = '0;
    ref_overflow = 1'b0;
    build_table();
    repeat (RESET_CYCLES) @(posedge clock);
    usb_rst <= 1'b0;
    @(posedge clock);

    check_value("tx_o", 32'(tx), 32'h1);
    check_value("dumping_o", 32'(dumping), 32'h0);
    check_value("busy_o", 32'(busy), 32'h0);
    check_value("overflow_o", 32'(overflow), 32'h0);
    end_test("reset state");

    apply_rows(0, 8);
    check_value("level_o", 32'(level), 32'(exp_q.size()));
    check_value("overflow_o", 32'(overflow), 32'(ref_overflow));
    end_test("capture filter");

    start_dump();
    finish_dump();
    check_dump();
    end_test("dump");

    apply_rows(9, 28);
    check_value("level_o", 32'(level), 32'(exp_q.size()));
    check_value("overflow_o", 32'(overflow), 32'(ref_overflow));
    start_dump();
    finish_dump();
    check_dump();
    end_test("overflow");

    apply_rows(29, 31);
    start_dump();
    pulse_start();  // Ignored, the dump is already running
    apply_rows(32, 34);
    finish_dump();
    check_dump();
    end_test("start while busy");

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
design/telemetry_pkg.sv
design/telemetry_logger.sv
design/dump_fsm.sv
design/baud_timer.sv
design/uart_tx_shift.sv
design/telemetry_uart_top.sv
bench/telemetry_uart_assertions.sv
bench/telemetry_uart_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the telemetry UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
  --top-module telemetry_uart_tb --Mdir "$BUILD_DIR" -f sim.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtelemetry_uart_tb" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" "$LOG_FILE"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
